// ==== include/mem_config.svh ====
//////////////////////////////
// memory subsystem configuration
// address width, capacity, tag count and latency
//////////////////////////////

`ifndef MEM_SUBSYSTEM_CONFIG_SVH
`define MEM_SUBSYSTEM_CONFIG_SVH

// byte address width
`define XLEN 32

// capacity of the memory model in bytes
`define MEM_SIZE_IN_BYTES 1024

// number of 64-bit lines in the array
`define MEM_64BIT_LINES (`MEM_SIZE_IN_BYTES / 8)

// usable tags are 1 to 15, tag 0 means none
`define NUM_MEM_TAGS 15

`define MEM_LATENCY_IN_CYCLES 4 // cycles a tag stays busy after acceptance

`endif

// ==== design/mem_pkg.sv ====
//////////////////////////////
// memory bus types
// bus commands and access sizes shared by requesters and memory
//////////////////////////////

package mem_pkg;

	//////////////////////////////
	// bus command
	//////////////////////////////
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0, // idle
		BUS_LOAD  = 2'h1, // read, data returns later under the tag
		BUS_STORE = 2'h2  // write, never returns
	} bus_command_e;

	//////////////////////////////
	// access size
	//////////////////////////////
	typedef enum logic [1:0] {
		BYTE   = 2'h0, // 8 bits, any address
		HALF   = 2'h1, // 16 bits, 2-byte aligned
		WORD   = 2'h2, // 32 bits, 4-byte aligned
		DOUBLE = 2'h3  // whole 64-bit line
	} mem_size_e;

endpackage

// ==== design/mem.sv ====
//////////////////////////////
// main memory model
// tagged and pipelined with a fixed latency
// size-aware loads and stores, one registered return bus
//////////////////////////////

`include "mem_config.svh"

module mem (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`XLEN-1:0]      proc2mem_addr,     // byte address
	input  logic [63:0]           proc2mem_data,     // store data, low bits for sub-word
	input  mem_pkg::mem_size_e    proc2mem_size,
	input  mem_pkg::bus_command_e proc2mem_command,
	output logic [3:0]            mem2proc_response, // tag of accepted request, 0 if refused
	output logic [3:0]            mem2proc_tag,      // tag of returning load, 0 if none
	output logic [63:0]           mem2proc_data
);

	localparam int LINE_W = $clog2(`MEM_64BIT_LINES);
	localparam int CNT_W  = $clog2(`MEM_LATENCY_IN_CYCLES + 1);

	logic [63:0]            unified_memory [0:`MEM_64BIT_LINES-1];
	logic [63:0]            loaded_data    [1:`NUM_MEM_TAGS];     // load result per tag
	logic [CNT_W-1:0]       cycles_left    [1:`NUM_MEM_TAGS];     // latency countdown
	logic [`NUM_MEM_TAGS:1] waiting_for_bus;                      // load done, not yet returned

	logic              valid_address;
	logic              acquire_tag;
	logic              accept;
	logic [3:0]        free_tag;  // lowest free tag
	logic [3:0]        ret_tag;   // lowest ready tag
	logic [LINE_W-1:0] line_idx;
	logic [63:0]       cur_line;
	logic [63:0]       load_value;
	logic [63:0]       merged_line;
	logic [5:0]        byte_off, half_off, word_off; // bit offsets of the addressed lane

	//////////////////////////////
	// request decode
	//////////////////////////////
	assign valid_address = proc2mem_addr < `XLEN'(`MEM_SIZE_IN_BYTES);
	assign acquire_tag   = ((proc2mem_command == mem_pkg::BUS_LOAD) ||
	                        (proc2mem_command == mem_pkg::BUS_STORE)) && valid_address;

	assign line_idx = proc2mem_addr[LINE_W+2:3];
	assign cur_line = unified_memory[line_idx];
	assign byte_off = {proc2mem_addr[2:0], 3'b000};
	assign half_off = {proc2mem_addr[2:1], 4'b0000};
	assign word_off = {proc2mem_addr[2], 5'b00000};

	// scan down so the lowest free tag wins
	always_comb begin
		free_tag = 4'd0;
		for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
			if ((cycles_left[i] == '0) && !waiting_for_bus[i])
				free_tag = 4'(i);
		end
	end

	assign mem2proc_response = acquire_tag ? free_tag : 4'd0; // 0 when full or out of range
	assign accept            = mem2proc_response != 4'd0;

	//////////////////////////////
	// lane select and merge
	//////////////////////////////
	always_comb begin
		case (proc2mem_size)
			mem_pkg::BYTE:   load_value = {56'b0, cur_line[byte_off +: 8]};
			mem_pkg::HALF:   load_value = {48'b0, cur_line[half_off +: 16]};
			mem_pkg::WORD:   load_value = {32'b0, cur_line[word_off +: 32]};
			default:         load_value = cur_line; // whole line
		endcase
	end

	always_comb begin
		merged_line = cur_line; // untouched lanes keep old bytes
		case (proc2mem_size)
			mem_pkg::BYTE:   merged_line[byte_off +: 8]  = proc2mem_data[7:0];
			mem_pkg::HALF:   merged_line[half_off +: 16] = proc2mem_data[15:0];
			mem_pkg::WORD:   merged_line[word_off +: 32] = proc2mem_data[31:0];
			default:         merged_line = proc2mem_data;
		endcase
	end

	// store lands at the accepting edge, later loads see it
	always @(posedge clk) begin
		if (accept && (proc2mem_command == mem_pkg::BUS_STORE))
			unified_memory[line_idx] <= merged_line;
	end

	always_ff @(posedge clk) begin
		if (accept && (proc2mem_command == mem_pkg::BUS_LOAD))
			loaded_data[mem2proc_response] <= load_value; // snapshot at acceptance
	end

	//////////////////////////////
	// tag state
	//////////////////////////////
	always_comb begin
		ret_tag = 4'd0;
		for (int i = `NUM_MEM_TAGS; i >= 1; i--) begin
			if (waiting_for_bus[i] && (cycles_left[i] == '0))
				ret_tag = 4'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i <= `NUM_MEM_TAGS; i++)
				cycles_left[i] <= '0;
			waiting_for_bus <= '0;
		end else begin
			for (int i = 1; i <= `NUM_MEM_TAGS; i++) begin
				if (accept && (mem2proc_response == 4'(i))) begin
					// return lands latency edges after this one
					cycles_left[i]     <= CNT_W'(`MEM_LATENCY_IN_CYCLES - 1);
					waiting_for_bus[i] <= proc2mem_command == mem_pkg::BUS_LOAD;
				end else begin
					if (cycles_left[i] != '0)
						cycles_left[i] <= cycles_left[i] - 1'b1;
					if (ret_tag == 4'(i))
						waiting_for_bus[i] <= 1'b0; // on the bus now, tag frees
				end
			end
		end
	end

	// return bus registers
	always_ff @(posedge clk) begin
		if (rst)
			mem2proc_tag <= 4'd0;
		else
			mem2proc_tag <= ret_tag;
	end

	always_ff @(posedge clk) begin
		if (ret_tag != 4'd0)
			mem2proc_data <= loaded_data[ret_tag];
	end

	// array starts zeroed
	initial begin
		for (int i = 0; i < `MEM_64BIT_LINES; i++)
			unified_memory[i] = 64'h0;
	end

	//////////////////////////////
	// alignment checks
	//////////////////////////////
	assert property (@(posedge clk) disable iff (rst)
		(accept && (proc2mem_size == mem_pkg::HALF)) |-> (proc2mem_addr[0] == 1'b0))
		else $error("mem: misaligned HALF access at %h", proc2mem_addr);

	assert property (@(posedge clk) disable iff (rst)
		(accept && (proc2mem_size == mem_pkg::WORD)) |-> (proc2mem_addr[1:0] == 2'b00))
		else $error("mem: misaligned WORD access at %h", proc2mem_addr);

endmodule

// ==== design/mem_arbiter.sv ====
//////////////////////////////
// memory arbiter
// round-robin grant between fetch and data ports
// tag ownership table steers returned loads
//////////////////////////////

`include "mem_config.svh"

module mem_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	// fetch port, double loads only
	input  logic [`XLEN-1:0]      fetch2mem_addr,
	input  mem_pkg::bus_command_e fetch2mem_command,
	// data port
	input  logic [`XLEN-1:0]      data2mem_addr,
	input  logic [63:0]           data2mem_data,
	input  mem_pkg::mem_size_e    data2mem_size,
	input  mem_pkg::bus_command_e data2mem_command,
	// from memory
	input  logic [3:0]            mem2proc_response,
	input  logic [3:0]            mem2proc_tag,
	input  logic [63:0]           mem2proc_data,
	// to memory
	output logic [`XLEN-1:0]      proc2mem_addr,
	output logic [63:0]           proc2mem_data,
	output mem_pkg::mem_size_e    proc2mem_size,
	output mem_pkg::bus_command_e proc2mem_command,
	// back to requesters
	output logic [3:0]            mem2fetch_response,
	output logic [3:0]            mem2fetch_tag,
	output logic [63:0]           mem2fetch_data,
	output logic [3:0]            mem2data_response,
	output logic [3:0]            mem2data_tag,
	output logic [63:0]           mem2data_data
);

	logic                   fetch_req, data_req;
	logic                   grant_fetch, grant_data;
	logic                   favor_data;  // round-robin pointer
	logic                   accepted;
	logic [`NUM_MEM_TAGS:1] owner_data;  // tag belongs to data port
	logic [`NUM_MEM_TAGS:1] owner_valid; // load outstanding under tag
	logic                   ret_valid, ret_to_data, ret_to_fetch;

	//////////////////////////////
	// grant and request mux
	//////////////////////////////
	assign fetch_req = fetch2mem_command != mem_pkg::BUS_NONE;
	assign data_req  = data2mem_command != mem_pkg::BUS_NONE;

	assign grant_data  = data_req && (!fetch_req || favor_data);
	assign grant_fetch = fetch_req && !grant_data;

	assign proc2mem_addr    = grant_data ? data2mem_addr : fetch2mem_addr;
	assign proc2mem_data    = grant_data ? data2mem_data : 64'h0; // fetch never stores
	assign proc2mem_size    = grant_data ? data2mem_size : mem_pkg::DOUBLE;
	assign proc2mem_command = grant_data ? data2mem_command : fetch2mem_command;

	// accept passes to the granted port only
	assign mem2fetch_response = grant_fetch ? mem2proc_response : 4'd0;
	assign mem2data_response  = grant_data ? mem2proc_response : 4'd0;
	assign accepted           = mem2proc_response != 4'd0;

	//////////////////////////////
	// ownership table
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			favor_data  <= 1'b0; // fetch goes first
			owner_data  <= '0;
			owner_valid <= '0;
		end else begin
			if (ret_valid)
				owner_valid[mem2proc_tag] <= 1'b0;
			if (accepted) begin
				favor_data <= !grant_data; // other port next time
				owner_data[mem2proc_response]  <= grant_data;
				owner_valid[mem2proc_response] <= proc2mem_command == mem_pkg::BUS_LOAD;
			end
		end
	end

	// return steering
	assign ret_valid    = mem2proc_tag != 4'd0;
	assign ret_to_data  = ret_valid && owner_data[mem2proc_tag];
	assign ret_to_fetch = ret_valid && !owner_data[mem2proc_tag];

	assign mem2data_tag   = ret_to_data ? mem2proc_tag : 4'd0;
	assign mem2data_data  = ret_to_data ? mem2proc_data : 64'h0;
	assign mem2fetch_tag  = ret_to_fetch ? mem2proc_tag : 4'd0;
	assign mem2fetch_data = ret_to_fetch ? mem2proc_data : 64'h0;

	//////////////////////////////
	// protocol checks
	//////////////////////////////
	assert property (@(posedge clk) disable iff (rst)
		!((mem2fetch_response != 4'd0) && (mem2data_response != 4'd0)))
		else $error("mem_arbiter: both ports accepted in one cycle");

	// every return matches a load recorded at acceptance
	assert property (@(posedge clk) disable iff (rst)
		ret_valid |-> owner_valid[mem2proc_tag])
		else $error("mem_arbiter: tag %0d returned with no owner", mem2proc_tag);

endmodule

// ==== design/mem_subsystem.sv ====
//////////////////////////////
// memory subsystem top level
// fetch and data ports share one memory via the arbiter
//////////////////////////////

`include "mem_config.svh"

module mem_subsystem (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`XLEN-1:0]      fetch2mem_addr,
	input  mem_pkg::bus_command_e fetch2mem_command,
	input  logic [`XLEN-1:0]      data2mem_addr,
	input  logic [63:0]           data2mem_data,
	input  mem_pkg::mem_size_e    data2mem_size,
	input  mem_pkg::bus_command_e data2mem_command,
	output logic [3:0]            mem2fetch_response,
	output logic [3:0]            mem2fetch_tag,
	output logic [63:0]           mem2fetch_data,
	output logic [3:0]            mem2data_response,
	output logic [3:0]            mem2data_tag,
	output logic [63:0]           mem2data_data
);

	// arbiter to memory
	logic [`XLEN-1:0]      proc2mem_addr;
	logic [63:0]           proc2mem_data;
	mem_pkg::mem_size_e    proc2mem_size;
	mem_pkg::bus_command_e proc2mem_command;
	// memory to arbiter
	logic [3:0]            mem2proc_response;
	logic [3:0]            mem2proc_tag;
	logic [63:0]           mem2proc_data;

	mem_arbiter mem_arbiter_i (
		.clk                (clk),
		.rst                (rst),
		.fetch2mem_addr     (fetch2mem_addr),
		.fetch2mem_command  (fetch2mem_command),
		.data2mem_addr      (data2mem_addr),
		.data2mem_data      (data2mem_data),
		.data2mem_size      (data2mem_size),
		.data2mem_command   (data2mem_command),
		.mem2proc_response  (mem2proc_response),
		.mem2proc_tag       (mem2proc_tag),
		.mem2proc_data      (mem2proc_data),
		.proc2mem_addr      (proc2mem_addr),
		.proc2mem_data      (proc2mem_data),
		.proc2mem_size      (proc2mem_size),
		.proc2mem_command   (proc2mem_command),
		.mem2fetch_response (mem2fetch_response),
		.mem2fetch_tag      (mem2fetch_tag),
		.mem2fetch_data     (mem2fetch_data),
		.mem2data_response  (mem2data_response),
		.mem2data_tag       (mem2data_tag),
		.mem2data_data      (mem2data_data)
	);

	mem mem_i (
		.clk               (clk),
		.rst               (rst),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.proc2mem_size     (proc2mem_size),
		.proc2mem_command  (proc2mem_command),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data)
	);

endmodule

// ==== verification/mem_subsystem_tb.sv ====
//////////////////////////////
// memory subsystem testbench
// directed tests with a byte-wise reference memory
//////////////////////////////

`include "mem_config.svh"

module mem_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 100; // limit for every wait loop

	logic                  clk = 1'b0;
	logic                  rst;
	logic [`XLEN-1:0]      fetch2mem_addr, data2mem_addr;
	logic [63:0]           data2mem_data;
	mem_pkg::mem_size_e    data2mem_size;
	mem_pkg::bus_command_e fetch2mem_command, data2mem_command;
	logic [3:0]            mem2fetch_response, mem2fetch_tag, mem2data_response, mem2data_tag;
	logic [63:0]           mem2fetch_data, mem2data_data;

	integer seed;
	int     errors = 0, checks = 0, tests = 0, failed = 0;
	bit     timed_out = 0;
	logic [7:0]  ref_mem [0:`MEM_SIZE_IN_BYTES-1]; // little-endian bytes
	bit          pend      [1:`NUM_MEM_TAGS];      // load outstanding under tag
	bit          pend_port [1:`NUM_MEM_TAGS];      // 1 = data port
	logic [63:0] pend_data [1:`NUM_MEM_TAGS];
	int          pending_count = 0;
	bit          grant_log [$]; // 1 = data port won

	mem_subsystem mem_subsystem_i (.*);

	always #5 clk = ~clk;

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic logic [63:0] ref_load(logic [31:0] addr, mem_pkg::mem_size_e size);
		logic [63:0] v;
		logic [31:0] base;
		v    = 64'h0; // zero-extend
		base = (size == mem_pkg::DOUBLE) ? {addr[31:3], 3'b000} : addr;
		for (int i = 0; i < (1 << int'(size)); i++)
			v[8*i +: 8] = ref_mem[base + i];
		return v;
	endfunction

	task automatic ref_store(logic [31:0] addr, mem_pkg::mem_size_e size, logic [63:0] wdata);
		logic [31:0] base;
		base = (size == mem_pkg::DOUBLE) ? {addr[31:3], 3'b000} : addr;
		for (int i = 0; i < (1 << int'(size)); i++)
			ref_mem[base + i] = wdata[8*i +: 8]; // low bytes land at the address
	endtask

	task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	//////////////////////////////
	// return monitor
	//////////////////////////////
	task automatic take_return(logic [3:0] tag, bit is_data, logic [63:0] data);
		if (!pend[tag]) begin
			errors++;
			$display("%0t ns: tag %0d returned with no load outstanding", $time, tag);
		end else begin
			if (pend_port[tag] != is_data) begin
				errors++;
				$display("%0t ns: tag %0d returned on the wrong port", $time, tag);
			end
			check(is_data ? "mem2data_data" : "mem2fetch_data", pend_data[tag], data);
			pend[tag] = 0;
			pending_count--;
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			if (mem2data_tag != 4'd0)
				take_return(mem2data_tag, 1'b1, mem2data_data);
			if (mem2fetch_tag != 4'd0)
				take_return(mem2fetch_tag, 1'b0, mem2fetch_data);
			if ((mem2data_response != 4'd0) && (mem2fetch_response != 4'd0)) begin
				errors++;
				$display("%0t ns: both ports accepted in the same cycle", $time);
			end
		end
	end

	//////////////////////////////
	// bus driving
	//////////////////////////////
	task automatic request(bit is_data, mem_pkg::bus_command_e cmd, logic [31:0] addr,
	                       mem_pkg::mem_size_e size, logic [63:0] wdata, output logic [3:0] tag);
		int waited;
		@(posedge clk);
		#1;
		if (is_data) begin
			data2mem_command = cmd;
			data2mem_addr    = addr;
			data2mem_size    = size;
			data2mem_data    = wdata;
		end else begin
			fetch2mem_command = cmd; // fetch is always a double load
			fetch2mem_addr    = addr;
		end
		tag    = 4'd0;
		waited = 0;
		while ((tag == 4'd0) && (waited < TIMEOUT_CYCLES)) begin
			@(negedge clk);
			#1; // after the monitor has taken this cycle's return
			tag = is_data ? mem2data_response : mem2fetch_response;
			waited++;
		end
		if (tag == 4'd0) begin
			errors++;
			timed_out = 1;
			$display("%0t ns: timeout, request at %h never accepted", $time, addr);
		end else begin
			grant_log.push_back(is_data);
			if (cmd == mem_pkg::BUS_STORE) begin
				ref_store(addr, size, wdata);
			end else begin
				if (pend[tag]) begin
					errors++;
					$display("%0t ns: tag %0d handed out again before its return", $time, tag);
				end
				pend[tag]      = 1;
				pend_port[tag] = is_data;
				pend_data[tag] = ref_load(addr, is_data ? size : mem_pkg::DOUBLE);
				pending_count++;
			end
		end
	endtask

	task automatic idle(bit is_data);
		@(posedge clk); // commit edge of the last request
		#1;
		if (is_data)
			data2mem_command = mem_pkg::BUS_NONE;
		else
			fetch2mem_command = mem_pkg::BUS_NONE;
	endtask

	task automatic wait_returns();
		int waited;
		waited = 0;
		while ((pending_count != 0) && (waited < TIMEOUT_CYCLES)) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (pending_count != 0) begin
			errors++;
			timed_out = 1;
			$display("%0t ns: timeout, %0d loads never returned", $time, pending_count);
		end
	endtask

	task automatic finish_test(string name, int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset();
		int e0;
		e0 = errors;
		@(negedge clk);
		#1;
		check("mem2fetch_response", 0, mem2fetch_response);
		check("mem2data_response", 0, mem2data_response);
		check("mem2fetch_tag", 0, mem2fetch_tag);
		check("mem2data_tag", 0, mem2data_tag);
		finish_test("reset values", e0);
	endtask

	task automatic test_double();
		int          e0;
		logic [3:0]  tag;
		logic [63:0] wdata;
		e0    = errors;
		wdata = {$random(seed), $random(seed)};
		request(1, mem_pkg::BUS_STORE, 32'h40, mem_pkg::DOUBLE, wdata, tag);
		check("mem2data_response", 1, tag); // all tags free, lowest one goes first
		request(1, mem_pkg::BUS_LOAD, 32'h40, mem_pkg::DOUBLE, 64'h0, tag);
		idle(1);
		wait_returns();
		request(0, mem_pkg::BUS_LOAD, 32'h40, mem_pkg::DOUBLE, 64'h0, tag); // same line via fetch
		idle(0);
		wait_returns();
		finish_test("double store and load", e0);
	endtask

	task automatic test_subword();
		int                 e0;
		logic [3:0]         tag;
		logic [31:0]        addr;
		mem_pkg::mem_size_e size;
		e0 = errors;
		for (int i = 0; i < 12; i++) begin
			size = mem_pkg::mem_size_e'(i % 3); // byte, half, word
			addr = 32'h100 + ($random(seed) & 32'h3f);
			addr = addr & ~((32'd1 << int'(size)) - 1); // natural alignment
			request(1, mem_pkg::BUS_STORE, addr, size, {$random(seed), $random(seed)}, tag);
		end
		for (int i = 0; i < 16; i++) begin
			size = mem_pkg::mem_size_e'($random(seed) & 3);
			addr = 32'h100 + ($random(seed) & 32'h3f);
			addr = addr & ~((32'd1 << int'(size)) - 1);
			request(1, mem_pkg::BUS_LOAD, addr, size, 64'h0, tag);
		end
		idle(1);
		wait_returns();
		finish_test("sub-word access", e0);
	endtask

	task automatic test_contention();
		int         e0;
		logic [3:0] tag_d, tag_f;
		e0 = errors;
		grant_log.delete();
		fork
			begin
				for (int k = 0; k < 3; k++)
					request(1, mem_pkg::BUS_LOAD, 32'h100 + 8*k, mem_pkg::WORD, 64'h0, tag_d);
				idle(1);
			end
			begin
				for (int k = 0; k < 3; k++)
					request(0, mem_pkg::BUS_LOAD, 32'h118 + 8*k, mem_pkg::DOUBLE, 64'h0, tag_f);
				idle(0);
			end
		join
		wait_returns();
		check("grant count", 6, grant_log.size());
		for (int i = 1; i < grant_log.size(); i++)
			check("grant order", !grant_log[i-1], grant_log[i]); // must flip each transfer
		finish_test("both ports together", e0);
	endtask

	// one accept per cycle against a 4-cycle latency, tags recycle before the pool drains
	task automatic test_tags();
		int                   e0;
		int                   max_pend;
		logic [3:0]           tag;
		bit [`NUM_MEM_TAGS:1] used;
		e0       = errors;
		max_pend = 0;
		used     = '0;
		for (int k = 0; k < 20; k++) begin
			request(1, mem_pkg::BUS_LOAD, 32'h100 + 4*k, mem_pkg::WORD, 64'h0, tag);
			if (tag != 4'd0)
				used[tag] = 1;
			if (pending_count > max_pend)
				max_pend = pending_count;
		end
		idle(1);
		wait_returns();
		// a tag is busy for the latency, then reused in the cycle after its return
		check("distinct tags", `MEM_LATENCY_IN_CYCLES + 1, $countones(used));
		check("loads outstanding", `MEM_LATENCY_IN_CYCLES + 1, max_pend);
		finish_test("tag recycling", e0);
	endtask

	task automatic test_out_of_range();
		int e0;
		e0 = errors;
		@(posedge clk);
		#1;
		data2mem_command = mem_pkg::BUS_LOAD;
		data2mem_addr    = `MEM_SIZE_IN_BYTES;
		data2mem_size    = mem_pkg::DOUBLE;
		repeat (20) begin
			@(negedge clk);
			#1;
			check("mem2data_response", 0, mem2data_response);
		end
		idle(1);
		finish_test("out of range address", e0);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		seed              = 9089;
		rst               = 1'b1;
		fetch2mem_addr    = '0;
		fetch2mem_command = mem_pkg::BUS_NONE;
		data2mem_addr     = '0;
		data2mem_data     = '0;
		data2mem_size     = mem_pkg::BYTE;
		data2mem_command  = mem_pkg::BUS_NONE;
		for (int i = 0; i < `MEM_SIZE_IN_BYTES; i++)
			ref_mem[i] = 8'h00; // matches the cleared array
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		test_reset();
		if (!timed_out)
			test_double();
		if (!timed_out)
			test_subword();
		if (!timed_out)
			test_contention();
		if (!timed_out)
			test_tags();
		if (!timed_out)
			test_out_of_range();

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== mem_subsystem.f ====
+incdir+include
design/mem_pkg.sv
design/mem.sv
design/mem_arbiter.sv
design/mem_subsystem.sv
verification/mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mem_pkg.sv
      - design/mem.sv
      - design/mem_arbiter.sv
      - design/mem_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mem_subsystem_tb.sv
